/* flist.f */
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_mul.sv
hdl/exu_csr.sv
hdl/exu_agu.sv
hdl/exu_writeback.sv
hdl/exu_top.sv
sim/tb_exu_top.sv

/* sim/tb_exu_top.sv */
// testbench for the execute slice, inputs change on the falling edge
// priority case relies on fixed unit latencies, units drained before it
// stops at the first mismatch, limit of 3000 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;

    logic                clk;
    logic                rst_i;
    exu_pkg::issue_t     issue_i;
    logic                int_assert_i;
    exu_pkg::wb_req_t    reg_wb_o;
    logic                wb_done_o;
    exu_pkg::unit_vec_t  busy_o;

    // scoreboard by rd
    exu_pkg::reg_data_t  exp_data [32];
    logic                outstanding [32];
    int                  outstanding_cnt;
    exu_pkg::reg_addr_t  next_rd;
    // reference state
    exu_pkg::reg_data_t  csr_m [exu_pkg::CSR_COUNT];
    exu_pkg::reg_data_t  mem_m [exu_pkg::DMEM_WORDS];
    // write log for ordering checks
    exu_pkg::reg_addr_t  wb_rd_q [$];
    int                  wb_cyc_q [$];
    int                  cycle_cnt;

    exu_top u_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .issue_i      (issue_i),
        .int_assert_i (int_assert_i),
        .reg_wb_o     (reg_wb_o),
        .wb_done_o    (wb_done_o),
        .busy_o       (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    // expected rd value, updates csr and memory models as a side effect
    function automatic exu_pkg::reg_data_t ref_result(input exu_pkg::unit_e unit,
            input exu_pkg::op_t op, input exu_pkg::reg_data_t a,
            input exu_pkg::reg_data_t b, input logic [11:0] imm);
        exu_pkg::reg_data_t res;
        exu_pkg::reg_data_t ea;
        int                 idx;
        res = '0;
        case (unit)
            exu_pkg::UNIT_ALU: begin
                case (op)
                    4'd0: res = a + b;
                    4'd1: res = a - b;
                    4'd2: res = a & b;
                    4'd3: res = a | b;
                    4'd4: res = a ^ b;
                    4'd5: res = a << b[4:0];
                    4'd6: res = a >> b[4:0];
                    4'd7: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: res = '0;
                endcase
            end
            exu_pkg::UNIT_MUL: res = a * b;
            exu_pkg::UNIT_CSR: begin
                // old value returned, update applied at issue
                res = csr_m[imm[1:0]];
                case (op)
                    4'd0: csr_m[imm[1:0]] = a;
                    4'd1: csr_m[imm[1:0]] = res | a;
                    4'd2: csr_m[imm[1:0]] = res & ~a;
                    default: ;
                endcase
            end
            default: begin
                ea  = a + {{20{imm[11]}}, imm};
                idx = ea[5:2];
                if (op == 4'd1) begin
                    mem_m[idx] = b;
                end else begin
                    res = mem_m[idx];
                end
            end
        endcase
        return res;
    endfunction

    // waits for the unit to be free, drives one issue cycle
    task automatic issue_op(input exu_pkg::unit_e unit, input exu_pkg::op_t op,
            input exu_pkg::reg_data_t a, input exu_pkg::reg_data_t b,
            input logic [11:0] imm, input bit expect_wb, output exu_pkg::reg_addr_t rd);
        exu_pkg::issue_t ins;
        while (busy_o[unit]) @(negedge clk);
        do begin
            next_rd = (next_rd == 5'd31) ? 5'd1 : next_rd + 5'd1;
        end while (outstanding[next_rd]);
        rd        = next_rd;
        ins.valid = 1'b1;
        ins.unit  = unit;
        ins.op    = op;
        ins.src_a = a;
        ins.src_b = b;
        ins.imm   = imm;
        ins.rd    = rd;
        exp_data[rd] = ref_result(unit, op, a, b, imm);
        if (expect_wb) begin
            outstanding[rd] = 1'b1;
            outstanding_cnt++;
        end
        issue_i = ins;
        @(negedge clk);
        issue_i = '0;
        // accepted unit is busy right after the issue edge
        assert (busy_o[unit]) else begin
            $display("** Error: busy_o[%0d] expected 0x1 actual 0x%0h", unit, busy_o[unit]);
            abort_run();
        end
    endtask

    // write port must stay quiet while the interrupt is high
    task automatic check_port_blocked();
        assert (!reg_wb_o.we && !wb_done_o) else begin
            $display("** Error: reg_wb_o.we expected 0x0 actual 0x%0h, wb_done_o actual 0x%0h",
                     reg_wb_o.we, wb_done_o);
            abort_run();
        end
    endtask

    task automatic drain();
        while (busy_o != '0) @(negedge clk);
    endtask

    // cycle limit, roughly 60 instructions at up to 40 cycles
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 3000) begin
            $display("timeout: no end of test after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    // compare process, values sampled before the edge updates them
    always @(posedge clk) begin
        if (!rst_i && reg_wb_o.we) begin
            assert (wb_done_o) else begin
                $display("** Error: wb_done_o expected 0x1 actual 0x%0h", wb_done_o);
                abort_run();
            end
            assert (outstanding[reg_wb_o.waddr]) else begin
                $display("** Error: reg_wb_o.waddr 0x%02h has no outstanding result",
                         reg_wb_o.waddr);
                abort_run();
            end
            assert (reg_wb_o.wdata == exp_data[reg_wb_o.waddr]) else begin
                $display("** Error: reg_wb_o.wdata rd 0x%02h expected 0x%08h actual 0x%08h",
                         reg_wb_o.waddr, exp_data[reg_wb_o.waddr], reg_wb_o.wdata);
                abort_run();
            end
            outstanding[reg_wb_o.waddr] = 1'b0;
            outstanding_cnt--;
            wb_rd_q.push_back(reg_wb_o.waddr);
            wb_cyc_q.push_back(cycle_cnt);
        end
    end

    initial begin : stimulus
        exu_pkg::reg_addr_t rd_t;
        exu_pkg::reg_addr_t rd_ld;
        exu_pkg::reg_addr_t rd_mul;
        exu_pkg::reg_addr_t rd_alu;
        int                 base;
        void'($urandom(32'h5ec9_0cd5));
        rst_i           = 1'b1;
        issue_i         = '0;
        int_assert_i    = 1'b0;
        outstanding_cnt = 0;
        next_rd         = 5'd0;
        cycle_cnt       = 0;
        for (int i = 0; i < 32; i++) begin
            outstanding[i] = 1'b0;
            exp_data[i]    = '0;
        end
        for (int i = 0; i < exu_pkg::CSR_COUNT; i++) csr_m[i] = '0;
        for (int i = 0; i < exu_pkg::DMEM_WORDS; i++) mem_m[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // random ALU ops
        for (int i = 0; i < 20; i++) begin
            issue_op(exu_pkg::UNIT_ALU, exu_pkg::op_t'($urandom % 8), $urandom, $urandom,
                     12'h000, 1'b1, rd_t);
        end
        drain();

        // multiplies, corner operands first
        issue_op(exu_pkg::UNIT_MUL, 4'd0, 32'hffff_ffff, 32'hffff_ffff, 12'h000, 1'b1, rd_t);
        issue_op(exu_pkg::UNIT_MUL, 4'd0, 32'h0000_0000, $urandom, 12'h000, 1'b1, rd_t);
        for (int i = 0; i < 4; i++) begin
            issue_op(exu_pkg::UNIT_MUL, 4'd0, $urandom, $urandom, 12'h000, 1'b1, rd_t);
        end
        drain();

        // csr rw, rs, rc per entry then read back with rs of zero
        for (int i = 0; i < exu_pkg::CSR_COUNT; i++) begin
            issue_op(exu_pkg::UNIT_CSR, 4'd0, $urandom, 32'd0, 12'(i), 1'b1, rd_t);
            issue_op(exu_pkg::UNIT_CSR, 4'd1, $urandom, 32'd0, 12'(i), 1'b1, rd_t);
            issue_op(exu_pkg::UNIT_CSR, 4'd2, $urandom, 32'd0, 12'(i), 1'b1, rd_t);
        end
        for (int i = 0; i < exu_pkg::CSR_COUNT; i++) begin
            issue_op(exu_pkg::UNIT_CSR, 4'd1, 32'd0, 32'd0, 12'(i), 1'b1, rd_t);
        end
        drain();

        // stores then loads, same word, unwritten word, negative offset
        for (int i = 0; i < 4; i++) begin
            issue_op(exu_pkg::UNIT_AGU, 4'd1, 32'h100, $urandom, 12'(4 * i), 1'b0, rd_t);
        end
        for (int i = 0; i < 4; i++) begin
            issue_op(exu_pkg::UNIT_AGU, 4'd0, 32'h100, 32'd0, 12'(4 * i), 1'b1, rd_t);
        end
        issue_op(exu_pkg::UNIT_AGU, 4'd0, 32'h100, 32'd0, 12'h014, 1'b1, rd_t);
        issue_op(exu_pkg::UNIT_AGU, 4'd1, 32'h104, $urandom, 12'h000, 1'b0, rd_t);
        issue_op(exu_pkg::UNIT_AGU, 4'd0, 32'h104, 32'd0, 12'h000, 1'b1, rd_t);
        issue_op(exu_pkg::UNIT_AGU, 4'd0, 32'h118, 32'd0, 12'hff0, 1'b1, rd_t);
        drain();

        // priority, load and ALU timed to be pending with the multiply
        base = wb_rd_q.size();
        issue_op(exu_pkg::UNIT_MUL, 4'd0, $urandom, $urandom, 12'h000, 1'b1, rd_mul);
        // mul writes MUL_CYCLES edges after issue, load two, ALU one
        repeat (exu_pkg::MUL_CYCLES - 3) @(negedge clk);
        issue_op(exu_pkg::UNIT_AGU, 4'd0, 32'h100, 32'd0, 12'h008, 1'b1, rd_ld);
        issue_op(exu_pkg::UNIT_ALU, 4'd0, $urandom, $urandom, 12'h000, 1'b1, rd_alu);
        drain();
        assert (wb_rd_q.size() == base + 3 && wb_rd_q[base] == rd_ld &&
                wb_rd_q[base + 1] == rd_mul && wb_rd_q[base + 2] == rd_alu) else begin
            $display("** Error: reg_wb_o.waddr order expected 0x%02h 0x%02h 0x%02h",
                     rd_ld, rd_mul, rd_alu);
            $display("** Error: reg_wb_o.waddr order actual 0x%02h 0x%02h 0x%02h",
                     wb_rd_q[base], wb_rd_q[base + 1], wb_rd_q[base + 2]);
            abort_run();
        end
        assert (wb_cyc_q[base + 1] == wb_cyc_q[base] + 1 &&
                wb_cyc_q[base + 2] == wb_cyc_q[base + 1] + 1) else begin
            $display("priority writes did not arrive on consecutive cycles");
            abort_run();
        end

        // interrupt flushes ALU and CSR results, csr update kept
        int_assert_i = 1'b1;
        issue_op(exu_pkg::UNIT_ALU, 4'd0, $urandom, $urandom, 12'h000, 1'b0, rd_t);
        check_port_blocked();
        issue_op(exu_pkg::UNIT_CSR, 4'd1, 32'h0000_f0f0, 32'd0, 12'h001, 1'b0, rd_t);
        check_port_blocked();
        repeat (4) begin
            @(negedge clk);
            check_port_blocked();
        end
        int_assert_i = 1'b0;
        issue_op(exu_pkg::UNIT_CSR, 4'd1, 32'd0, 32'd0, 12'h001, 1'b1, rd_t);
        drain();

        assert (outstanding_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("results still outstanding at end of test: %0d", outstanding_cnt);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* hdl/exu_top.sv */
// execute and writeback slice, four units sharing one write port
// caller must not issue to a unit whose busy bit is set
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire                      clk,
    input  wire                      rst_i,
    input  wire exu_pkg::issue_t     issue_i,
    input  wire                      int_assert_i,
    output exu_pkg::wb_req_t         reg_wb_o,
    output logic                     wb_done_o,
    output wire exu_pkg::unit_vec_t  busy_o
);

    // per-unit pending results
    exu_pkg::wb_req_t    alu_req;
    exu_pkg::wb_req_t    mul_req;
    exu_pkg::wb_req_t    csr_req;
    exu_pkg::wb_req_t    agu_req;
    // one retire bit per unit from the arbiter
    exu_pkg::unit_vec_t  retire;

    // issue fans out, each unit decodes its own
    exu_alu u_alu (
        .clk      (clk),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .retire_i (retire[exu_pkg::UNIT_ALU]),
        .req_o    (alu_req),
        .busy_o   (busy_o[exu_pkg::UNIT_ALU])
    );

    exu_mul u_mul (
        .clk      (clk),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .retire_i (retire[exu_pkg::UNIT_MUL]),
        .req_o    (mul_req),
        .busy_o   (busy_o[exu_pkg::UNIT_MUL])
    );

    exu_csr u_csr (
        .clk      (clk),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .retire_i (retire[exu_pkg::UNIT_CSR]),
        .req_o    (csr_req),
        .busy_o   (busy_o[exu_pkg::UNIT_CSR])
    );

    exu_agu u_agu (
        .clk      (clk),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .retire_i (retire[exu_pkg::UNIT_AGU]),
        .req_o    (agu_req),
        .busy_o   (busy_o[exu_pkg::UNIT_AGU])
    );

    exu_writeback u_writeback (
        .alu_req_i    (alu_req),
        .mul_req_i    (mul_req),
        .csr_req_i    (csr_req),
        .agu_req_i    (agu_req),
        .int_assert_i (int_assert_i),
        .reg_wb_o     (reg_wb_o),
        .wb_done_o    (wb_done_o),
        .retire_o     (retire)
    );

endmodule

`default_nettype wire

/* hdl/exu_writeback.sv */
// fixed-priority owner of the register write port: AGU, MUL, ALU, CSR
// interrupt blocks the port and drops every pending result
// purely combinational, retire takes effect at the unit's next edge
`timescale 1ns/1ps
`default_nettype none

module exu_writeback (
    input  wire exu_pkg::wb_req_t alu_req_i,
    input  wire exu_pkg::wb_req_t mul_req_i,
    input  wire exu_pkg::wb_req_t csr_req_i,
    input  wire exu_pkg::wb_req_t agu_req_i,
    input  wire                   int_assert_i,
    output exu_pkg::wb_req_t      reg_wb_o,
    output logic                  wb_done_o,
    output exu_pkg::unit_vec_t    retire_o
);

    always_comb begin
        reg_wb_o  = '0;
        wb_done_o = 1'b0;
        retire_o  = '0;
        if (int_assert_i) begin
            // no write, flush all pending units
            retire_o[exu_pkg::UNIT_AGU] = agu_req_i.we;
            retire_o[exu_pkg::UNIT_MUL] = mul_req_i.we;
            retire_o[exu_pkg::UNIT_ALU] = alu_req_i.we;
            retire_o[exu_pkg::UNIT_CSR] = csr_req_i.we;
        end else if (agu_req_i.we) begin
            // load data first
            reg_wb_o                    = agu_req_i;
            wb_done_o                   = 1'b1;
            retire_o[exu_pkg::UNIT_AGU] = 1'b1;
        end else if (mul_req_i.we) begin
            reg_wb_o                    = mul_req_i;
            wb_done_o                   = 1'b1;
            retire_o[exu_pkg::UNIT_MUL] = 1'b1;
        end else if (alu_req_i.we) begin
            reg_wb_o                    = alu_req_i;
            wb_done_o                   = 1'b1;
            retire_o[exu_pkg::UNIT_ALU] = 1'b1;
        end else if (csr_req_i.we) begin
            // lowest priority
            reg_wb_o                    = csr_req_i;
            wb_done_o                   = 1'b1;
            retire_o[exu_pkg::UNIT_CSR] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/exu_agu.sv */
// address unit with a small word-addressed data memory
// loads pending two cycles after issue, stores raise no request
// address wraps on the memory depth, low two bits ignored
`timescale 1ns/1ps
`default_nettype none

module exu_agu (
    input  wire                clk,
    input  wire                rst_i,
    input  wire exu_pkg::issue_t issue_i,
    input  wire                retire_i,
    output exu_pkg::wb_req_t   req_o,
    output logic               busy_o
);

    exu_pkg::reg_data_t               dmem_q [exu_pkg::DMEM_WORDS];
    exu_pkg::reg_data_t               addr;
    logic                             accept;
    // stage 1, registered address
    logic                             s1_vld_q;
    logic                             s1_st_q;
    logic [exu_pkg::DMEM_IDX_W-1:0]   s1_idx_q;
    exu_pkg::reg_data_t               s1_data_q;
    // stage 2, load data pending
    logic                             pend_q;
    exu_pkg::reg_data_t               res_q;
    exu_pkg::reg_addr_t               rd_q;

    assign accept = issue_i.valid && (issue_i.unit == exu_pkg::UNIT_AGU) && !busy_o;

    // base plus sign-extended offset
    assign addr = issue_i.src_a +
                  {{(exu_pkg::XLEN-exu_pkg::IMM_W){issue_i.imm[exu_pkg::IMM_W-1]}}, issue_i.imm};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_vld_q <= 1'b0;
            pend_q   <= 1'b0;
        end else begin
            s1_vld_q <= accept;
            if (s1_vld_q && !s1_st_q) begin
                pend_q <= 1'b1;
            end else if (retire_i) begin
                pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_st_q   <= (exu_pkg::agu_op_e'(issue_i.op) == exu_pkg::AGU_STORE);
            s1_idx_q  <= addr[exu_pkg::DMEM_IDX_W+1:2];
            s1_data_q <= issue_i.src_b;
            rd_q      <= issue_i.rd;
        end
        // load read, one edge after the address
        if (s1_vld_q && !s1_st_q) begin
            res_q <= dmem_q[s1_idx_q];
        end
    end

    // data memory, store lands one edge after issue
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < exu_pkg::DMEM_WORDS; i++) begin
                dmem_q[i] <= '0;
            end
        end else if (s1_vld_q && s1_st_q) begin
            dmem_q[s1_idx_q] <= s1_data_q;
        end
    end

    assign req_o.we    = pend_q;
    assign req_o.waddr = rd_q;
    assign req_o.wdata = res_q;
    // store busy only while in stage 1
    assign busy_o      = s1_vld_q | pend_q;

endmodule

`default_nettype wire

/* hdl/exu_csr.sv */
// small scratch CSR file, selected by low imm bits
// array updated at issue, even if the old value is later discarded
`timescale 1ns/1ps
`default_nettype none

module exu_csr (
    input  wire                clk,
    input  wire                rst_i,
    input  wire exu_pkg::issue_t issue_i,
    input  wire                retire_i,
    output exu_pkg::wb_req_t   req_o,
    output logic               busy_o
);

    exu_pkg::reg_data_t              csr_q [exu_pkg::CSR_COUNT];
    logic [exu_pkg::CSR_SEL_W-1:0]   sel;
    exu_pkg::reg_data_t              old_val;
    exu_pkg::reg_data_t              new_val;
    exu_pkg::reg_data_t              res_q;
    exu_pkg::reg_addr_t              rd_q;
    logic                            pend_q;
    logic                            accept;

    assign accept  = issue_i.valid && (issue_i.unit == exu_pkg::UNIT_CSR) && !pend_q;
    assign sel     = issue_i.imm[exu_pkg::CSR_SEL_W-1:0];
    assign old_val = csr_q[sel];

    // update rule per op
    always_comb begin
        case (exu_pkg::csr_op_e'(issue_i.op))
            exu_pkg::CSR_RW: new_val = issue_i.src_a;
            exu_pkg::CSR_RS: new_val = old_val | issue_i.src_a;
            exu_pkg::CSR_RC: new_val = old_val & ~issue_i.src_a;
            default:         new_val = old_val;
        endcase
    end

    // CSR array, cleared on reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < exu_pkg::CSR_COUNT; i++) begin
                csr_q[i] <= '0;
            end
        end else if (accept) begin
            csr_q[sel] <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pend_q <= 1'b0;
        end else if (accept) begin
            pend_q <= 1'b1;
        end else if (retire_i) begin
            pend_q <= 1'b0;
        end
    end

    // old value goes back to rd
    always_ff @(posedge clk) begin
        if (accept) begin
            res_q <= old_val;
            rd_q  <= issue_i.rd;
        end
    end

    assign req_o.we    = pend_q;
    assign req_o.waddr = rd_q;
    assign req_o.wdata = res_q;
    assign busy_o      = pend_q;

endmodule

`default_nettype wire

/* hdl/exu_mul.sv */
// shift-and-add multiplier, low word of the product only
// result pending MUL_CYCLES cycles after issue, one job at a time
`timescale 1ns/1ps
`default_nettype none

module exu_mul (
    input  wire                clk,
    input  wire                rst_i,
    input  wire exu_pkg::issue_t issue_i,
    input  wire                retire_i,
    output exu_pkg::wb_req_t   req_o,
    output logic               busy_o
);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    mul_state_e                      state_q;
    logic [exu_pkg::MUL_CNT_W-1:0]   cnt_q;
    exu_pkg::reg_data_t              mcand_q;
    exu_pkg::reg_data_t              mplier_q;
    exu_pkg::reg_data_t              acc_q;
    exu_pkg::reg_data_t              acc_next;
    exu_pkg::reg_addr_t              rd_q;
    logic                            accept;

    assign accept = issue_i.valid && (issue_i.unit == exu_pkg::UNIT_MUL) &&
                    (state_q == MUL_IDLE);

    // add shifted multiplicand when current multiplier bit set
    assign acc_next = mplier_q[0] ? (acc_q + mcand_q) : acc_q;

    // control
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (accept) begin
                        state_q <= MUL_RUN;
                        cnt_q   <= 1;
                    end
                end
                MUL_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    // last of 32 steps lands on the pending edge
                    if (cnt_q == exu_pkg::MUL_CNT_W'(exu_pkg::MUL_CYCLES - 1)) begin
                        state_q <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    if (retire_i) begin
                        state_q <= MUL_IDLE;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    // datapath, one partial product per run cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand_q  <= issue_i.src_a;
            mplier_q <= issue_i.src_b;
            acc_q    <= '0;
            rd_q     <= issue_i.rd;
        end else if (state_q == MUL_RUN) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign req_o.we    = (state_q == MUL_DONE);
    assign req_o.waddr = rd_q;
    assign req_o.wdata = acc_q;
    assign busy_o      = (state_q != MUL_IDLE);

endmodule

`default_nettype wire

/* hdl/exu_alu.sv */
// single-cycle integer ALU, result pending one cycle after issue
// issue while busy is ignored, caller must check busy_o
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  wire                clk,
    input  wire                rst_i,
    input  wire exu_pkg::issue_t issue_i,
    input  wire                retire_i,
    output exu_pkg::wb_req_t   req_o,
    output logic               busy_o
);

    logic                pend_q;
    exu_pkg::reg_addr_t  rd_q;
    exu_pkg::reg_data_t  res_q;
    exu_pkg::reg_data_t  alu_res;
    logic                accept;
    logic                lt_flag;

    // only this unit, only when free
    assign accept = issue_i.valid && (issue_i.unit == exu_pkg::UNIT_ALU) && !pend_q;

    // signed compare for slt
    assign lt_flag = $signed(issue_i.src_a) < $signed(issue_i.src_b);

    always_comb begin
        case (exu_pkg::alu_op_e'(issue_i.op))
            exu_pkg::ALU_ADD: alu_res = issue_i.src_a + issue_i.src_b;
            exu_pkg::ALU_SUB: alu_res = issue_i.src_a - issue_i.src_b;
            exu_pkg::ALU_AND: alu_res = issue_i.src_a & issue_i.src_b;
            exu_pkg::ALU_OR:  alu_res = issue_i.src_a | issue_i.src_b;
            exu_pkg::ALU_XOR: alu_res = issue_i.src_a ^ issue_i.src_b;
            // shift amount from low 5 bits only
            exu_pkg::ALU_SLL: alu_res = issue_i.src_a << issue_i.src_b[4:0];
            exu_pkg::ALU_SRL: alu_res = issue_i.src_a >> issue_i.src_b[4:0];
            exu_pkg::ALU_SLT: alu_res = {{(exu_pkg::XLEN-1){1'b0}}, lt_flag};
            default:          alu_res = '0;
        endcase
    end

    // pending flag
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pend_q <= 1'b0;
        end else if (accept) begin
            pend_q <= 1'b1;
        end else if (retire_i) begin
            pend_q <= 1'b0;
        end
    end

    // result and target held until retired
    always_ff @(posedge clk) begin
        if (accept) begin
            res_q <= alu_res;
            rd_q  <= issue_i.rd;
        end
    end

    assign req_o.we    = pend_q;
    assign req_o.waddr = rd_q;
    assign req_o.wdata = res_q;
    assign busy_o      = pend_q;

endmodule

`default_nettype wire

/* hdl/exu_pkg.sv */
// shared widths, unit and opcode encodings for the execute slice
// op field meaning depends on the unit named in the issue
`default_nettype none

package exu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 12;
    // issue edge to pending result: capture plus 32 add steps
    localparam int MUL_CYCLES = 33;
    localparam int DMEM_WORDS = 16;
    localparam int CSR_COUNT  = 4;
    localparam int NUM_UNITS  = 4;

    // derived select and counter widths
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);
    localparam int CSR_SEL_W  = $clog2(CSR_COUNT);
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

    typedef logic [XLEN-1:0]       reg_data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            op_t;

    // value doubles as bit index into unit_vec_t
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_CSR = 2'd2,
        UNIT_AGU = 2'd3
    } unit_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

    typedef enum logic [3:0] {
        CSR_RW = 4'd0,
        CSR_RS = 4'd1,
        CSR_RC = 4'd2
    } csr_op_e;

    typedef enum logic [3:0] {
        AGU_LOAD  = 4'd0,
        AGU_STORE = 4'd1
    } agu_op_e;

    typedef struct packed {
        logic             valid;
        unit_e            unit;
        op_t              op;
        reg_data_t        src_a;
        reg_data_t        src_b;
        logic [IMM_W-1:0] imm;
        reg_addr_t        rd;
    } issue_t;

    // we is a pending level, held until retired
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        reg_data_t wdata;
    } wb_req_t;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;

endpackage

`default_nettype wire
